// File: build.f
source/rvPkg.sv
source/rvAlu.sv
source/rvImmGen.sv
source/rvRegFile.sv
source/rvDecoder.sv
source/rvDatapath.sv
source/rvDataMem.sv
source/rvCore.sv
sim/tbRvCore.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tbRvCore
FILELIST  := build.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASSTEXT  := Simulation PASSED

# every source named in the file list, include lines skipped
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim/tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore;

    localparam int numInstr = 3000;
    localparam int resetCycles = 16;
    // program length plus reset, with some slack
    localparam int cycleLimit = numInstr + resetCycles + 184;
    localparam int romWords = 256;

    logic        clk;
    logic        arstN;
    logic [31:0] instruction;
    logic [4:0]  readRegisterDebug;
    logic [31:0] pc;
    logic [31:0] readDataDebug;
    logic        illegal;

    // program rom and reference state
    logic [31:0] rom [romWords];
    logic [31:0] mPc;
    logic [31:0] mRegs [32];
    logic [31:0] mRam [rvPkg::dataMemWords];
    logic [4:0]  dbgIdx;
    int          errorCount = 0;
    int          cycleCount = 0;

    rvCore rvCore_i (
        .clk(clk),
        .arstN(arstN),
        .instruction(instruction),
        .readRegisterDebug(readRegisterDebug),
        .pc(pc),
        .readDataDebug(readDataDebug),
        .illegal(illegal)
    );

    function automatic logic [4:0] pickReg();
        return 5'($urandom % 32);
    endfunction

    // one random instruction of the supported mix
    function automatic logic [31:0] makeInstr();
        int unsigned pick;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [12:0] offB;
        logic [20:0] offJ;
        pick = $urandom % 100;
        f3 = 3'($urandom % 8);
        if (pick < 2) begin
            // system opcode or a multiply, both unsupported
            if ($urandom % 2 == 0) begin
                return {25'($urandom), 7'b1110011};
            end
            return {7'b0000001, pickReg(), pickReg(), f3, pickReg(), 7'b0110011};
        end else if (pick < 32) begin
            f7 = 7'b0000000;
            if ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) begin
                f7 = 7'b0100000;
            end
            return {f7, pickReg(), pickReg(), f3, pickReg(), 7'b0110011};
        end else if (pick < 57) begin
            imm12 = 12'($urandom);
            if (f3 == 3'b001) begin
                imm12[11:5] = 7'b0000000;
            end else if (f3 == 3'b101) begin
                imm12[11:5] = ($urandom % 2 == 1) ? 7'b0100000 : 7'b0000000;
            end
            return {imm12, pickReg(), f3, pickReg(), 7'b0010011};
        end else if (pick < 65) begin
            f7 = ($urandom % 2 == 1) ? 7'b0110111 : 7'b0010111;
            return {20'($urandom), pickReg(), f7};
        end else if (pick < 75) begin
            // word load, x0 base keeps it inside the ram
            imm12 = 12'(($urandom % 64) * 4);
            return {imm12, 5'd0, 3'b010, pickReg(), 7'b0000011};
        end else if (pick < 85) begin
            imm12 = 12'(($urandom % 64) * 4);
            return {imm12[11:5], pickReg(), 5'd0, 3'b010, imm12[4:0], 7'b0100011};
        end else if (pick < 94) begin
            // funct3 010 and 011 are not branches
            while (f3 == 3'b010 || f3 == 3'b011) begin
                f3 = 3'($urandom % 8);
            end
            offB = 13'((1 + $urandom % 8) * 4);
            return {offB[12], offB[10:5], pickReg(), pickReg(), f3, offB[4:1], offB[11],
                7'b1100011};
        end else if (pick < 97) begin
            offJ = 21'((1 + $urandom % 8) * 4);
            return {offJ[20], offJ[10:1], offJ[11], offJ[19:12], pickReg(), 7'b1101111};
        end
        // jalr off x0 lands in the low part of the rom
        imm12 = 12'(($urandom % 64) * 4);
        return {imm12, 5'd0, 3'b000, pickReg(), 7'b1100111};
    endfunction

    // integer result by funct3, alt selects sub and sra
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // executes one instruction on the model, returns its illegal flag
    function automatic logic stepModel(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] val;
        logic [31:0] nextPc;
        logic        wr;
        logic        bad;
        logic        take;
        rd = ins[11:7];
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = mRegs[ins[19:15]];
        b = mRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'h000};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = mPc + 32'd4;
        val = 32'd0;
        wr = 1'b0;
        bad = 1'b0;
        take = 1'b0;
        case (ins[6:0])
            7'b0110111: begin
                wr = 1'b1;
                val = immU;
            end
            7'b0010111: begin
                wr = 1'b1;
                val = mPc + immU;
            end
            7'b1101111: begin
                wr = 1'b1;
                val = mPc + 32'd4;
                nextPc = mPc + immJ;
            end
            7'b1100111: begin
                if (f3 != 3'b000) begin
                    bad = 1'b1;
                end else begin
                    wr = 1'b1;
                    val = mPc + 32'd4;
                    nextPc = (a + immI) & 32'hffff_fffe;
                end
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: bad = 1'b1;
                endcase
                if (take) begin
                    nextPc = mPc + immB;
                end
            end
            7'b0000011: begin
                if (f3 != 3'b010) begin
                    bad = 1'b1;
                end else begin
                    addr = a + immI;
                    wr = 1'b1;
                    val = mRam[addr[9:2]];
                end
            end
            7'b0100011: begin
                if (f3 != 3'b010) begin
                    bad = 1'b1;
                end else begin
                    addr = a + immS;
                    mRam[addr[9:2]] = b;
                end
            end
            7'b0010011: begin
                if (f3 == 3'b001 && f7 != 7'h00) begin
                    bad = 1'b1;
                end else if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) begin
                    bad = 1'b1;
                end else begin
                    wr = 1'b1;
                    val = aluRef(f3, f3 == 3'b101 && f7 == 7'h20, a, immI);
                end
            end
            7'b0110011: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
                    wr = 1'b1;
                    val = aluRef(f3, f7[5], a, b);
                end else begin
                    bad = 1'b1;
                end
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        // x0 is never written
        if (wr && rd != 5'd0) begin
            mRegs[rd] = val;
        end
        mPc = nextPc;
        return bad;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errorCount++;
        $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic finishRun();
        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // stimulus and instruction rom
    initial begin
        void'($urandom(32'he3dc63c3));
        for (int i = 0; i < romWords; i++) begin
            rom[i] = makeInstr();
        end
        mPc = 32'd0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = 32'd0;
        end
        for (int i = 0; i < rvPkg::dataMemWords; i++) begin
            mRam[i] = 32'd0;
        end
        dbgIdx = 5'd0;
        arstN = 1'b0;
        instruction = rom[0];
        readRegisterDebug = 5'd0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            instruction = rom[pc[9:2]];
            dbgIdx = dbgIdx + 5'd1;
            readRegisterDebug = dbgIdx;
        end
    end

    // compare with the model midway through each cycle
    initial begin
        logic expIllegal;
        wait (arstN === 1'b1);
        for (int n = 0; n < numInstr; n++) begin
            @(negedge clk);
            assert (pc === mPc)
                else reportMismatch("pc", pc, mPc);
            assert (readDataDebug === mRegs[dbgIdx])
                else reportMismatch($sformatf("readDataDebug[x%0d]", dbgIdx),
                    readDataDebug, mRegs[dbgIdx]);
            expIllegal = stepModel(rom[mPc[9:2]]);
            assert (illegal === expIllegal)
                else reportMismatch("illegal", {31'b0, illegal}, {31'b0, expIllegal});
        end
        finishRun();
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        errorCount++;
        $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
        finishRun();
    end

endmodule

// File: source/rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [rvPkg::xlen-1:0]         instruction,
    input  logic [rvPkg::regAddrWidth-1:0] readRegisterDebug,
    output logic [rvPkg::xlen-1:0]         pc,
    output logic [rvPkg::xlen-1:0]         readDataDebug,
    output logic                           illegal
);

    rvPkg::memReqS          memReq;
    logic [rvPkg::xlen-1:0] memReadData;

    // instruction memory lives outside, data memory inside
    rvDatapath datapath_i (
        .clk(clk),
        .arstN(arstN),
        .instruction(instruction),
        .memReadData(memReadData),
        .readRegisterDebug(readRegisterDebug),
        .pc(pc),
        .memReq(memReq),
        .readDataDebug(readDataDebug),
        .illegal(illegal)
    );

    rvDataMem dataMem_i (
        .clk(clk),
        .arstN(arstN),
        .req(memReq),
        .readData(memReadData)
    );

endmodule

// File: source/rvDataMem.sv
`timescale 1ns/1ps

module rvDataMem (
    input  logic                   clk,
    input  logic                   arstN,
    input  rvPkg::memReqS          req,
    output logic [rvPkg::xlen-1:0] readData
);

    logic [rvPkg::xlen-1:0]             ram [rvPkg::dataMemWords];
    logic [rvPkg::dataMemAddrWidth-1:0] wordIdx;

    // byte address to word index, upper bits wrap
    assign wordIdx = req.addr[rvPkg::dataMemAddrWidth+1:2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < rvPkg::dataMemWords; i++) begin
                ram[i] <= '0;
            end
        end else if (req.write) begin
            ram[wordIdx] <= req.writeData;
        end
    end

    // only loads see memory data
    assign readData = req.read ? ram[wordIdx] : '0;

    // word stores only
    assert property (@(posedge clk) disable iff (!arstN)
        req.write |-> (req.addr[1:0] == 2'b00))
        else $error("rvDataMem: misaligned store to %h", req.addr);

endmodule

// File: source/rvDatapath.sv
`timescale 1ns/1ps

module rvDatapath (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [rvPkg::xlen-1:0]         instruction,
    input  logic [rvPkg::xlen-1:0]         memReadData,
    input  logic [rvPkg::regAddrWidth-1:0] readRegisterDebug,
    output logic [rvPkg::xlen-1:0]         pc,
    output rvPkg::memReqS                  memReq,
    output logic [rvPkg::xlen-1:0]         readDataDebug,
    output logic                           illegal
);

    rvPkg::ctrlS            ctrl;
    rvPkg::branchCondS      cond;
    rvPkg::immS             imm;
    logic [rvPkg::xlen-1:0] pc4;
    logic [rvPkg::xlen-1:0] pcNext;
    logic [rvPkg::xlen-1:0] branchTarget;
    logic [rvPkg::xlen-1:0] jalTarget;
    logic [rvPkg::xlen-1:0] jalrTarget;
    logic [rvPkg::xlen-1:0] rs1;
    logic [rvPkg::xlen-1:0] rs2;
    logic [rvPkg::xlen-1:0] aluA;
    logic [rvPkg::xlen-1:0] aluB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] wbData;

    rvDecoder decoder_i (
        .instruction(instruction),
        .cond(cond),
        .ctrl(ctrl)
    );

    rvImmGen immGen_i (
        .instruction(instruction),
        .pc(pc),
        .imm(imm),
        .branchTarget(branchTarget),
        .jalTarget(jalTarget)
    );

    rvRegFile regFile_i (
        .clk(clk),
        .arstN(arstN),
        .readAddr1(instruction[19:15]),
        .readAddr2(instruction[24:20]),
        .writeAddr(instruction[11:7]),
        .readRegisterDebug(readRegisterDebug),
        .writeData(wbData),
        .writeEnable(ctrl.regWrite),
        .readData1(rs1),
        .readData2(rs2),
        .readDataDebug(readDataDebug)
    );

    rvAlu alu_i (
        .aluOp(ctrl.aluOp),
        .a(aluA),
        .b(aluB),
        .rs1(rs1),
        .rs2(rs2),
        .result(aluResult),
        .cond(cond)
    );

    assign pc4 = pc + 32'd4;
    // jalr drops bit 0 of the sum
    assign jalrTarget = (rs1 + imm.i) & ~32'd1;

    always_comb begin
        case (ctrl.pcSel)
            rvPkg::pcBranch: pcNext = branchTarget;
            rvPkg::pcJal:    pcNext = jalTarget;
            rvPkg::pcJalr:   pcNext = jalrTarget;
            default:         pcNext = pc4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // operand selection
    always_comb begin
        case (ctrl.op1Sel)
            rvPkg::op1Pc:   aluA = pc;
            rvPkg::op1Zero: aluA = '0;
            default:        aluA = rs1;
        endcase
        case (ctrl.op2Sel)
            rvPkg::op2ImmI: aluB = imm.i;
            rvPkg::op2ImmS: aluB = imm.s;
            rvPkg::op2ImmU: aluB = imm.u;
            default:        aluB = rs2;
        endcase
    end

    // writeback
    always_comb begin
        case (ctrl.wbSel)
            rvPkg::wbMem: wbData = memReadData;
            rvPkg::wbPc4: wbData = pc4;
            default:      wbData = aluResult;
        endcase
    end

    assign memReq.addr = aluResult;
    assign memReq.writeData = rs2;
    assign memReq.read = ctrl.memRead;
    assign memReq.write = ctrl.memWrite;
    assign illegal = ctrl.illegal;

    // targets must keep fetch on word boundaries
    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("rvDatapath: misaligned pc %h", pc);

endmodule

// File: source/rvDecoder.sv
`timescale 1ns/1ps

module rvDecoder (
    input  logic [rvPkg::xlen-1:0] instruction,
    input  rvPkg::branchCondS      cond,
    output rvPkg::ctrlS            ctrl
);

    rvPkg::opcodeE opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          taken;
    logic          bad;

    // alu function selected by funct3 alone
    function automatic rvPkg::aluOpE aluBase(input logic [2:0] f3);
        case (f3)
            3'b000:  return rvPkg::aluAdd;
            3'b001:  return rvPkg::aluSll;
            3'b010:  return rvPkg::aluSlt;
            3'b011:  return rvPkg::aluSltu;
            3'b100:  return rvPkg::aluXor;
            3'b101:  return rvPkg::aluSrl;
            3'b110:  return rvPkg::aluOr;
            default: return rvPkg::aluAnd;
        endcase
    endfunction

    assign opcode = rvPkg::opcodeE'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // branch decision, 010 and 011 are rejected below
    always_comb begin
        case (funct3)
            3'b000:  taken = cond.eq;
            3'b001:  taken = !cond.eq;
            3'b100:  taken = cond.lt;
            3'b101:  taken = !cond.lt;
            3'b110:  taken = cond.ltu;
            3'b111:  taken = !cond.ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.pcSel = rvPkg::pcPlus4;
        ctrl.op1Sel = rvPkg::op1Rs1;
        ctrl.op2Sel = rvPkg::op2Rs2;
        ctrl.aluOp = rvPkg::aluAdd;
        ctrl.wbSel = rvPkg::wbAlu;
        ctrl.regWrite = 1'b0;
        ctrl.memRead = 1'b0;
        ctrl.memWrite = 1'b0;
        bad = 1'b0;
        case (opcode)
            rvPkg::opcLui: begin
                ctrl.op1Sel = rvPkg::op1Zero;
                ctrl.op2Sel = rvPkg::op2ImmU;
                ctrl.aluOp = rvPkg::aluCopyB;
                ctrl.regWrite = 1'b1;
            end
            rvPkg::opcAuipc: begin
                ctrl.op1Sel = rvPkg::op1Pc;
                ctrl.op2Sel = rvPkg::op2ImmU;
                ctrl.regWrite = 1'b1;
            end
            rvPkg::opcJal: begin
                ctrl.pcSel = rvPkg::pcJal;
                ctrl.wbSel = rvPkg::wbPc4;
                ctrl.regWrite = 1'b1;
            end
            rvPkg::opcJalr: begin
                ctrl.pcSel = rvPkg::pcJalr;
                ctrl.wbSel = rvPkg::wbPc4;
                ctrl.regWrite = 1'b1;
                bad = (funct3 != 3'b000);
            end
            rvPkg::opcBranch: begin
                ctrl.pcSel = taken ? rvPkg::pcBranch : rvPkg::pcPlus4;
                bad = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            rvPkg::opcLoad: begin
                ctrl.op2Sel = rvPkg::op2ImmI;
                ctrl.wbSel = rvPkg::wbMem;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                bad = (funct3 != rvPkg::funct3Word);
            end
            rvPkg::opcStore: begin
                ctrl.op2Sel = rvPkg::op2ImmS;
                ctrl.memWrite = 1'b1;
                bad = (funct3 != rvPkg::funct3Word);
            end
            rvPkg::opcOpImm: begin
                ctrl.op2Sel = rvPkg::op2ImmI;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = aluBase(funct3);
                // shift immediates carry funct7 in the upper imm bits
                if (funct3 == 3'b001) begin
                    bad = (funct7 != rvPkg::funct7Base);
                end else if (funct3 == 3'b101) begin
                    if (funct7 == rvPkg::funct7Alt) begin
                        ctrl.aluOp = rvPkg::aluSra;
                    end else begin
                        bad = (funct7 != rvPkg::funct7Base);
                    end
                end
            end
            rvPkg::opcOp: begin
                ctrl.regWrite = 1'b1;
                if (funct7 == rvPkg::funct7Base) begin
                    ctrl.aluOp = aluBase(funct3);
                end else if (funct7 == rvPkg::funct7Alt && funct3 == 3'b000) begin
                    ctrl.aluOp = rvPkg::aluSub;
                end else if (funct7 == rvPkg::funct7Alt && funct3 == 3'b101) begin
                    ctrl.aluOp = rvPkg::aluSra;
                end else begin
                    bad = 1'b1;
                end
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        // illegal behaves as a plain pc+4 with no side effects
        if (bad) begin
            ctrl.pcSel = rvPkg::pcPlus4;
            ctrl.regWrite = 1'b0;
            ctrl.memRead = 1'b0;
            ctrl.memWrite = 1'b0;
        end
        ctrl.illegal = bad;
    end

    // load and store share one memory request
    always_comb begin
        assert final (!(ctrl.memRead && ctrl.memWrite))
            else $error("rvDecoder: memRead and memWrite both set");
    end

endmodule

// File: source/rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [rvPkg::regAddrWidth-1:0] readAddr1,
    input  logic [rvPkg::regAddrWidth-1:0] readAddr2,
    input  logic [rvPkg::regAddrWidth-1:0] writeAddr,
    input  logic [rvPkg::regAddrWidth-1:0] readRegisterDebug,
    input  logic [rvPkg::xlen-1:0]         writeData,
    input  logic                           writeEnable,
    output logic [rvPkg::xlen-1:0]         readData1,
    output logic [rvPkg::xlen-1:0]         readData2,
    output logic [rvPkg::xlen-1:0]         readDataDebug
);

    logic [rvPkg::xlen-1:0] regs [rvPkg::numRegs];

    // x0 is cleared at reset and never written afterwards
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < rvPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];
    assign readDataDebug = regs[readRegisterDebug];

    // zero register holds across all writes
    assert property (@(posedge clk) disable iff (!arstN)
        (readAddr1 == '0) |-> (readData1 == '0))
        else $error("rvRegFile: x0 read returned %h", readData1);

endmodule

// File: source/rvImmGen.sv
`timescale 1ns/1ps

module rvImmGen (
    input  logic [rvPkg::xlen-1:0] instruction,
    input  logic [rvPkg::xlen-1:0] pc,
    output rvPkg::immS             imm,
    output logic [rvPkg::xlen-1:0] branchTarget,
    output logic [rvPkg::xlen-1:0] jalTarget
);

    logic sign;

    assign sign = instruction[31];

    // I type, loads, jalr and op-imm
    assign imm.i = {{21{sign}}, instruction[30:20]};

    // S type, stores
    assign imm.s = {{21{sign}}, instruction[30:25], instruction[11:7]};

    // B type, bit 0 always zero
    assign imm.b = {
        {20{sign}},
        instruction[7],
        instruction[30:25],
        instruction[11:8],
        1'b0
    };

    // U type already sits in the upper bits
    assign imm.u = {instruction[31:12], 12'b0};

    // J type
    assign imm.j = {
        {12{sign}},
        instruction[19:12],
        instruction[20],
        instruction[30:21],
        1'b0
    };

    // pc relative targets
    assign branchTarget = pc + imm.b;
    assign jalTarget = pc + imm.j;

endmodule

// File: source/rvAlu.sv
`timescale 1ns/1ps

module rvAlu (
    input  rvPkg::aluOpE           aluOp,
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  logic [rvPkg::xlen-1:0] rs1,
    input  logic [rvPkg::xlen-1:0] rs2,
    output logic [rvPkg::xlen-1:0] result,
    output rvPkg::branchCondS      cond
);

    logic [rvPkg::shamtWidth-1:0] shamt;

    assign shamt = b[rvPkg::shamtWidth-1:0];

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:   result = a + b;
            rvPkg::aluSub:   result = a - b;
            rvPkg::aluSll:   result = a << shamt;
            rvPkg::aluSlt:   result = rvPkg::xlen'($signed(a) < $signed(b));
            rvPkg::aluSltu:  result = rvPkg::xlen'(a < b);
            rvPkg::aluXor:   result = a ^ b;
            rvPkg::aluSrl:   result = a >> shamt;
            rvPkg::aluSra:   result = $signed(a) >>> shamt;
            rvPkg::aluOr:    result = a | b;
            rvPkg::aluAnd:   result = a & b;
            rvPkg::aluCopyB: result = b;
            default:         result = '0;
        endcase
    end

    // branch comparator works on the raw register values
    assign cond.eq = (rs1 == rs2);
    assign cond.lt = ($signed(rs1) < $signed(rs2));
    assign cond.ltu = (rs1 < rs2);

endmodule

// File: source/rvPkg.sv
package rvPkg;

    // widths and sizes
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs = 32;
    localparam int shamtWidth = 5;
    localparam int dataMemWords = 256;
    localparam int dataMemAddrWidth = 8;

    // funct fields used by the decoder
    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt = 7'b0100000;
    localparam logic [2:0] funct3Word = 3'b010;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcBranch = 7'b1100011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcOpImm  = 7'b0010011,
        opcOp     = 7'b0110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluCopyB
    } aluOpE;

    typedef enum logic [1:0] {
        pcPlus4,
        pcBranch,
        pcJal,
        pcJalr
    } pcSelE;

    typedef enum logic [1:0] {
        op1Rs1,
        op1Pc,
        op1Zero
    } op1SelE;

    typedef enum logic [1:0] {
        op2Rs2,
        op2ImmI,
        op2ImmS,
        op2ImmU
    } op2SelE;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPc4
    } wbSelE;

    // rs1 versus rs2 comparison results
    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } branchCondS;

    typedef struct packed {
        logic [xlen-1:0] i;
        logic [xlen-1:0] s;
        logic [xlen-1:0] b;
        logic [xlen-1:0] u;
        logic [xlen-1:0] j;
    } immS;

    typedef struct packed {
        pcSelE  pcSel;
        op1SelE op1Sel;
        op2SelE op2Sel;
        aluOpE  aluOp;
        wbSelE  wbSel;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   illegal;
    } ctrlS;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] writeData;
        logic            read;
        logic            write;
    } memReqS;

endpackage
